//--- src/lc4_consts.svh
`ifndef LC4_CONSTS_SVH
`define LC4_CONSTS_SVH

`define LC4_RESET_PC      16'h8200  // first fetch after reset
`define LC4_NUM_REGS      8

// opcode field, insn[15:12]
`define LC4_OP_BR         4'b0000
`define LC4_OP_ARITH      4'b0001   // ADD only, register or imm5 form
`define LC4_OP_LOGIC      4'b0101   // AND register form
`define LC4_OP_LDR        4'b0110
`define LC4_OP_STR        4'b0111
`define LC4_OP_CONST      4'b1001

// stall codes reported at writeback
`define LC4_STALL_NONE    2'd0
`define LC4_STALL_BUBBLE  2'd2      // reset bubble or flushed by a branch
`define LC4_STALL_LOAD    2'd3      // load-use or load-branch bubble

`endif

//--- src/lc4_pkg.sv
package lc4_pkg;

    typedef logic [15:0] word_t;     // data or address
    typedef logic [2:0]  reg_sel_t;  // register number
    typedef logic [2:0]  nzp_t;      // {n, z, p}
    typedef logic [1:0]  stall_t;

    // per-instruction control, squashed to zero for bubbles
    typedef struct packed {
        logic rs_re;
        logic rt_re;
        logic rf_we;
        logic nzp_we;
        logic is_load;
        logic is_store;
    } ctrl_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_sel_t   rd;
        reg_sel_t   rs;
        logic [2:0] subop;
        reg_sel_t   rt;
    } insn_rr_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_sel_t   rd;
        reg_sel_t   rs;
        logic       imm_flag;  // set for the imm5 form of ADD
        logic [4:0] imm5;
    } insn_ri_t;

    typedef struct packed {
        logic [3:0] opcode;
        reg_sel_t   rd_rt;     // rd for LDR, rt for STR
        reg_sel_t   rs;
        logic [5:0] offset6;
    } insn_mem_t;

    typedef struct packed {
        logic [3:0] opcode;
        nzp_t       nzp;       // branch mask, rd for CONST
        logic [8:0] imm9;
    } insn_br_t;

    // one instruction word, four ways to read it
    typedef union packed {
        insn_rr_t  rr;
        insn_ri_t  ri;
        insn_mem_t mem;
        insn_br_t  br;
    } lc4_insn_t;

endpackage

//--- src/lc4_stage_if.sv
// decode outputs into the D/X register
interface lc4_dx_if import lc4_pkg::*; ();
    word_t     pc;
    lc4_insn_t insn;
    reg_sel_t  rs_sel;
    reg_sel_t  rt_sel;
    reg_sel_t  rd_sel;
    word_t     rs_data;   // regfile values, already WD bypassed
    word_t     rt_data;
    ctrl_t     ctrl;
    stall_t    stall;

    modport src (output pc, insn, rs_sel, rt_sel, rd_sel, rs_data, rt_data, ctrl, stall);
    modport dst (input  pc, insn, rs_sel, rt_sel, rd_sel, rs_data, rt_data, ctrl, stall);
endinterface

// execute results into the X/M register
interface lc4_xm_if import lc4_pkg::*; ();
    word_t     pc;
    lc4_insn_t insn;
    reg_sel_t  rt_sel;      // kept for WM bypass of store data
    reg_sel_t  rd_sel;
    word_t     alu_result;
    word_t     store_data;
    ctrl_t     ctrl;
    stall_t    stall;

    modport src (output pc, insn, rt_sel, rd_sel, alu_result, store_data, ctrl, stall);
    modport dst (input  pc, insn, rt_sel, rd_sel, alu_result, store_data, ctrl, stall);
endinterface

// memory and writeback stage results fed back to execute
interface lc4_bypass_if import lc4_pkg::*; ();
    reg_sel_t m_rd_sel;
    logic     m_rf_we;
    word_t    m_rf_data;
    logic     m_nzp_we;
    nzp_t     m_nzp;
    reg_sel_t w_rd_sel;
    logic     w_rf_we;
    word_t    w_rf_data;
    logic     w_nzp_we;
    nzp_t     w_nzp;
    nzp_t     nzp;          // committed condition code

    modport src (output m_rd_sel, m_rf_we, m_rf_data, m_nzp_we, m_nzp,
                        w_rd_sel, w_rf_we, w_rf_data, w_nzp_we, w_nzp, nzp);
    modport dst (input  m_rd_sel, m_rf_we, m_rf_data, m_nzp_we, m_nzp,
                        w_rd_sel, w_rf_we, w_rf_data, w_nzp_we, w_nzp, nzp);
endinterface

//--- src/lc4_fetch.sv
`include "lc4_consts.svh"

module lc4_fetch import lc4_pkg::*; (
    input  logic  gwe,
    input  logic  i_rst,
    input  logic  i_stall,     // load hazard in decode
    input  logic  i_redirect,  // taken branch in execute
    input  word_t i_target,
    output word_t o_pc
);

    word_t pc;
    word_t pc_next;

    // redirect wins over a stall, the wrong-path fetch gets flushed anyway
    always_comb begin
        pc_next = pc + 16'd1;
        if (i_redirect) begin
            pc_next = i_target;
        end else if (i_stall) begin
            pc_next = pc;  // refetch same word
        end
    end

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            pc <= `LC4_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    assign o_pc = pc;  // straight to instruction memory

endmodule

//--- src/lc4_decode.sv
`include "lc4_consts.svh"

module lc4_decode import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst,
    input  word_t    i_insn,
    input  word_t    i_pc,
    input  logic     i_stall_x_load,  // execute holds a live load
    input  logic     i_redirect,
    output logic     o_stall,
    output reg_sel_t o_rs_sel,
    output reg_sel_t o_rt_sel,
    input  word_t    i_rs_data,
    input  word_t    i_rt_data,
    lc4_dx_if.src    dx
);

    word_t     d_pc;
    lc4_insn_t d_insn;
    stall_t    d_stall;      // bubble until the first real fetch lands
    reg_sel_t  x_rd_shadow;  // rd of whatever went to execute last cycle
    ctrl_t     ctrl_raw;
    ctrl_t     ctrl_out;
    stall_t    out_stall;
    logic      live_branch;
    logic      hazard;

    // F/D register, held while stalling
    always_ff @(posedge gwe) begin
        if (i_rst || i_redirect) begin
            d_stall <= `LC4_STALL_BUBBLE;  // wrong-path fetch becomes a flush bubble
        end else if (!o_stall) begin
            d_stall <= `LC4_STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!o_stall) begin
            d_pc   <= i_pc;
            d_insn <= i_insn;
        end
        x_rd_shadow <= d_insn.rr.rd;  // execute loads every cycle
    end

    // field order rs_re, rt_re, rf_we, nzp_we, is_load, is_store
    always_comb begin
        case (d_insn.rr.opcode)
            `LC4_OP_ARITH: ctrl_raw = '{1'b1, !d_insn.ri.imm_flag, 1'b1, 1'b1, 1'b0, 1'b0};
            `LC4_OP_LOGIC: ctrl_raw = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0};  // any subop is AND
            `LC4_OP_CONST: ctrl_raw = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0};
            `LC4_OP_LDR:   ctrl_raw = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0};
            `LC4_OP_STR:   ctrl_raw = '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
            default:       ctrl_raw = '0;  // BR and unsupported opcodes
        endcase
    end

    assign o_rs_sel = d_insn.rr.rs;
    assign o_rt_sel = ctrl_raw.is_store ? d_insn.mem.rd_rt : d_insn.rr.rt;

    // a BR with empty mask is a nop and cannot depend on a load
    assign live_branch = (d_insn.br.opcode == `LC4_OP_BR) && (d_insn.br.nzp != 3'b000);

    // store data from a load is covered by WM bypass, no stall for rt of STR
    assign hazard = (ctrl_raw.rs_re && o_rs_sel == x_rd_shadow)
                  || (ctrl_raw.rt_re && !ctrl_raw.is_store && o_rt_sel == x_rd_shadow)
                  || live_branch;

    assign o_stall = i_stall_x_load && hazard && (d_stall == `LC4_STALL_NONE);

    always_comb begin
        if (i_redirect) begin
            out_stall = `LC4_STALL_BUBBLE;   // flushed by the branch in execute
        end else if (d_stall != `LC4_STALL_NONE) begin
            out_stall = d_stall;
        end else if (o_stall) begin
            out_stall = `LC4_STALL_LOAD;
        end else begin
            out_stall = `LC4_STALL_NONE;
        end
        ctrl_out = ctrl_raw;
        if (out_stall != `LC4_STALL_NONE) begin
            ctrl_out.rf_we    = 1'b0;  // no architectural side effects
            ctrl_out.nzp_we   = 1'b0;
            ctrl_out.is_store = 1'b0;
        end
    end

    assign dx.pc      = d_pc;
    assign dx.insn    = d_insn;
    assign dx.rs_sel  = o_rs_sel;
    assign dx.rt_sel  = o_rt_sel;
    assign dx.rd_sel  = d_insn.rr.rd;
    assign dx.rs_data = i_rs_data;
    assign dx.rt_data = i_rt_data;
    assign dx.ctrl    = ctrl_out;
    assign dx.stall   = out_stall;

endmodule

//--- src/lc4_regfile.sv
`include "lc4_consts.svh"

module lc4_regfile import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst,
    input  reg_sel_t i_rs_sel,
    input  reg_sel_t i_rt_sel,
    output word_t    o_rs_data,
    output word_t    o_rt_data,
    input  reg_sel_t i_rd_sel,   // writeback port
    input  word_t    i_rd_data,
    input  logic     i_rd_we
);

    word_t regs [`LC4_NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            for (int i = 0; i < `LC4_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_rd_data;
        end
    end

    // WD bypass, decode sees this cycle's writeback
    assign o_rs_data = (i_rd_we && i_rd_sel == i_rs_sel) ? i_rd_data : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && i_rd_sel == i_rt_sel) ? i_rd_data : regs[i_rt_sel];

endmodule

//--- src/lc4_execute.sv
`include "lc4_consts.svh"

module lc4_execute import lc4_pkg::*; (
    input  logic       gwe,
    input  logic       i_rst,
    lc4_dx_if.dst      dx,
    lc4_bypass_if.dst  byp,
    lc4_xm_if.src      xm,
    output logic       o_x_load,    // live load here, decode checks dependence
    output logic       o_redirect,
    output word_t      o_target
);

    word_t     x_pc;
    lc4_insn_t x_insn;
    reg_sel_t  x_rs_sel;
    reg_sel_t  x_rt_sel;
    reg_sel_t  x_rd_sel;
    word_t     x_rs_data;
    word_t     x_rt_data;
    ctrl_t     x_ctrl;
    stall_t    x_stall;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm5_sx;
    word_t     imm6_sx;
    word_t     imm9_sx;
    word_t     br_target;
    word_t     alu_result;
    nzp_t      nzp_fwd;
    logic      live;

    // D/X register, loads every cycle since decode sends bubbles when it stalls
    always_ff @(posedge gwe) begin
        if (i_rst) begin
            x_ctrl  <= '0;
            x_stall <= `LC4_STALL_BUBBLE;
        end else begin
            x_ctrl  <= dx.ctrl;
            x_stall <= dx.stall;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc      <= dx.pc;
        x_insn    <= dx.insn;
        x_rs_sel  <= dx.rs_sel;
        x_rt_sel  <= dx.rt_sel;
        x_rd_sel  <= dx.rd_sel;
        x_rs_data <= dx.rs_data;
        x_rt_data <= dx.rt_data;
    end

    // youngest producer wins, bubbles never have rf_we set
    function automatic word_t bypass_operand(input reg_sel_t sel, input word_t rf_val);
        if (byp.m_rf_we && byp.m_rd_sel == sel) begin
            return byp.m_rf_data;  // MX
        end
        if (byp.w_rf_we && byp.w_rd_sel == sel) begin
            return byp.w_rf_data;  // WX
        end
        return rf_val;
    endfunction

    always_comb begin
        rs_val = bypass_operand(x_rs_sel, x_rs_data);
        rt_val = bypass_operand(x_rt_sel, x_rt_data);
    end

    assign imm5_sx   = {{11{x_insn.ri.imm5[4]}}, x_insn.ri.imm5};
    assign imm6_sx   = {{10{x_insn.mem.offset6[5]}}, x_insn.mem.offset6};
    assign imm9_sx   = {{7{x_insn.br.imm9[8]}}, x_insn.br.imm9};
    assign br_target = x_pc + 16'd1 + imm9_sx;  // relative to pc+1

    always_comb begin
        case (x_insn.rr.opcode)
            `LC4_OP_ARITH: alu_result = rs_val + (x_insn.ri.imm_flag ? imm5_sx : rt_val);
            `LC4_OP_LOGIC: alu_result = rs_val & rt_val;
            `LC4_OP_CONST: alu_result = imm9_sx;
            `LC4_OP_LDR,
            `LC4_OP_STR:   alu_result = rs_val + imm6_sx;  // effective address
            default:       alu_result = br_target;
        endcase
    end

    // NZP from the youngest older writer, else the committed copy
    assign nzp_fwd = byp.m_nzp_we ? byp.m_nzp :
                     byp.w_nzp_we ? byp.w_nzp : byp.nzp;

    assign live       = (x_stall == `LC4_STALL_NONE);
    assign o_x_load   = live && x_ctrl.is_load;
    assign o_redirect = live && (x_insn.br.opcode == `LC4_OP_BR)
                             && |(x_insn.br.nzp & nzp_fwd);
    assign o_target   = br_target;

    assign xm.pc         = x_pc;
    assign xm.insn       = x_insn;
    assign xm.rt_sel     = x_rt_sel;
    assign xm.rd_sel     = x_rd_sel;
    assign xm.alu_result = alu_result;
    assign xm.store_data = rt_val;  // STR data already bypassed
    assign xm.ctrl       = x_ctrl;
    assign xm.stall      = x_stall;

endmodule

//--- src/lc4_mem_writeback.sv
`include "lc4_consts.svh"

module lc4_mem_writeback import lc4_pkg::*; (
    input  logic       gwe,
    input  logic       i_rst,
    lc4_xm_if.dst      xm,
    lc4_bypass_if.src  byp,
    output word_t      o_dmem_addr,
    output logic       o_dmem_we,
    output word_t      o_dmem_wdata,
    input  word_t      i_dmem_rdata,   // combinational read of o_dmem_addr
    output reg_sel_t   o_rd_sel,
    output word_t      o_rd_data,
    output logic       o_rd_we,
    output word_t      o_wb_pc,
    output word_t      o_wb_insn,
    output stall_t     o_wb_stall,
    output logic       o_wb_nzp_we,
    output nzp_t       o_wb_nzp
);

    word_t     m_pc;
    lc4_insn_t m_insn;
    reg_sel_t  m_rt_sel;
    reg_sel_t  m_rd_sel;
    word_t     m_alu;
    word_t     m_store_data;
    ctrl_t     m_ctrl;
    stall_t    m_stall;
    word_t     m_rf_data;
    nzp_t      m_nzp;
    word_t     w_pc;
    lc4_insn_t w_insn;
    reg_sel_t  w_rd_sel;
    word_t     w_rf_data;
    nzp_t      w_nzp;
    logic      w_rf_we;
    logic      w_nzp_we;
    stall_t    w_stall;
    nzp_t      nzp_q;      // committed condition code

    always_ff @(posedge gwe) begin
        if (i_rst) begin
            m_ctrl   <= '0;
            m_stall  <= `LC4_STALL_BUBBLE;
            w_rf_we  <= 1'b0;
            w_nzp_we <= 1'b0;
            w_stall  <= `LC4_STALL_BUBBLE;
            nzp_q    <= '0;
        end else begin
            m_ctrl   <= xm.ctrl;
            m_stall  <= xm.stall;
            w_rf_we  <= m_ctrl.rf_we;
            w_nzp_we <= m_ctrl.nzp_we;
            w_stall  <= m_stall;
            if (w_nzp_we) begin
                nzp_q <= w_nzp;  // commit at end of writeback
            end
        end
    end

    always_ff @(posedge gwe) begin
        m_pc         <= xm.pc;
        m_insn       <= xm.insn;
        m_rt_sel     <= xm.rt_sel;
        m_rd_sel     <= xm.rd_sel;
        m_alu        <= xm.alu_result;
        m_store_data <= xm.store_data;
        w_pc         <= m_pc;
        w_insn       <= m_insn;
        w_rd_sel     <= m_rd_sel;
        w_rf_data    <= m_rf_data;
        w_nzp        <= m_nzp;
    end

    assign o_dmem_addr  = (m_ctrl.is_load || m_ctrl.is_store) ? m_alu : '0;
    assign o_dmem_we    = m_ctrl.is_store;
    // WM bypass when the value to store is being written back right now
    assign o_dmem_wdata = (m_ctrl.is_store && w_rf_we && w_rd_sel == m_rt_sel) ?
                          w_rf_data : m_store_data;

    assign m_rf_data = m_ctrl.is_load ? i_dmem_rdata : m_alu;
    assign m_nzp     = m_rf_data[15]       ? 3'b100 :
                       (m_rf_data == '0)   ? 3'b010 : 3'b001;

    assign byp.m_rd_sel  = m_rd_sel;
    assign byp.m_rf_we   = m_ctrl.rf_we && !m_ctrl.is_load;  // loads forward from writeback only
    assign byp.m_rf_data = m_rf_data;
    assign byp.m_nzp_we  = m_ctrl.nzp_we;
    assign byp.m_nzp     = m_nzp;
    assign byp.w_rd_sel  = w_rd_sel;
    assign byp.w_rf_we   = w_rf_we;
    assign byp.w_rf_data = w_rf_data;
    assign byp.w_nzp_we  = w_nzp_we;
    assign byp.w_nzp     = w_nzp;
    assign byp.nzp       = nzp_q;

    // regfile write port doubles as the trace
    assign o_rd_sel    = w_rd_sel;
    assign o_rd_data   = w_rf_data;
    assign o_rd_we     = w_rf_we;
    assign o_wb_pc     = w_pc;
    assign o_wb_insn   = w_insn;
    assign o_wb_stall  = w_stall;
    assign o_wb_nzp_we = w_nzp_we;
    assign o_wb_nzp    = w_nzp;

endmodule

//--- src/lc4_core.sv
module lc4_core import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_rst,
    output word_t    o_pc,          // to instruction memory
    input  word_t    i_insn,
    output word_t    o_dmem_addr,
    output logic     o_dmem_we,
    output word_t    o_dmem_wdata,
    input  word_t    i_dmem_rdata,
    output word_t    o_wb_pc,       // writeback trace
    output word_t    o_wb_insn,
    output stall_t   o_wb_stall,
    output logic     o_wb_rf_we,
    output reg_sel_t o_wb_rf_wsel,
    output word_t    o_wb_rf_wdata,
    output logic     o_wb_nzp_we,
    output nzp_t     o_wb_nzp
);

    logic     stall;
    logic     redirect;
    logic     x_load;
    word_t    target;
    reg_sel_t rs_sel;
    reg_sel_t rt_sel;
    word_t    rs_data;
    word_t    rt_data;

    lc4_dx_if     dx_if ();
    lc4_xm_if     xm_if ();
    lc4_bypass_if byp_if ();

    lc4_fetch fetch_inst (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .i_stall    (stall),
        .i_redirect (redirect),
        .i_target   (target),
        .o_pc       (o_pc)
    );

    lc4_decode decode_inst (
        .gwe            (gwe),
        .i_rst          (i_rst),
        .i_insn         (i_insn),
        .i_pc           (o_pc),
        .i_stall_x_load (x_load),
        .i_redirect     (redirect),
        .o_stall        (stall),
        .o_rs_sel       (rs_sel),
        .o_rt_sel       (rt_sel),
        .i_rs_data      (rs_data),
        .i_rt_data      (rt_data),
        .dx             (dx_if.src)
    );

    lc4_regfile regfile_inst (
        .gwe       (gwe),
        .i_rst     (i_rst),
        .i_rs_sel  (rs_sel),
        .i_rt_sel  (rt_sel),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_rd_sel  (o_wb_rf_wsel),
        .i_rd_data (o_wb_rf_wdata),
        .i_rd_we   (o_wb_rf_we)
    );

    lc4_execute execute_inst (
        .gwe        (gwe),
        .i_rst      (i_rst),
        .dx         (dx_if.dst),
        .byp        (byp_if.dst),
        .xm         (xm_if.src),
        .o_x_load   (x_load),
        .o_redirect (redirect),
        .o_target   (target)
    );

    lc4_mem_writeback mem_wb_inst (
        .gwe          (gwe),
        .i_rst        (i_rst),
        .xm           (xm_if.dst),
        .byp          (byp_if.src),
        .o_dmem_addr  (o_dmem_addr),
        .o_dmem_we    (o_dmem_we),
        .o_dmem_wdata (o_dmem_wdata),
        .i_dmem_rdata (i_dmem_rdata),
        .o_rd_sel     (o_wb_rf_wsel),
        .o_rd_data    (o_wb_rf_wdata),
        .o_rd_we      (o_wb_rf_we),
        .o_wb_pc      (o_wb_pc),
        .o_wb_insn    (o_wb_insn),
        .o_wb_stall   (o_wb_stall),
        .o_wb_nzp_we  (o_wb_nzp_we),
        .o_wb_nzp     (o_wb_nzp)
    );

endmodule

//--- tests/lc4_tb.sv
`include "lc4_consts.svh"

module lc4_tb import lc4_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // one retired writeback entry
    typedef struct packed {
        word_t    pc;
        word_t    insn;
        stall_t   stall;
        logic     rf_we;
        reg_sel_t sel;
        word_t    data;
        logic     nzp_we;
        nzp_t     nzp;
    } entry_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } store_t;

    localparam word_t nop_insn = 16'h0000;  // BR with empty mask

    logic     gwe;
    logic     i_rst;
    word_t    o_pc;
    word_t    i_insn;
    word_t    o_dmem_addr;
    logic     o_dmem_we;
    word_t    o_dmem_wdata;
    word_t    i_dmem_rdata;
    word_t    o_wb_pc;
    word_t    o_wb_insn;
    stall_t   o_wb_stall;
    logic     o_wb_rf_we;
    reg_sel_t o_wb_rf_wsel;
    word_t    o_wb_rf_wdata;
    logic     o_wb_nzp_we;
    nzp_t     o_wb_nzp;

    word_t  imem [64];     // slot = pc - reset pc
    word_t  dmem [65536];
    entry_t trace[$];      // writeback entries from the first real one on
    store_t stores[$];
    int     errors;
    int     passed;
    int     failed;

    lc4_core lc4_core_inst (
        .gwe           (gwe),
        .i_rst         (i_rst),
        .o_pc          (o_pc),
        .i_insn        (i_insn),
        .o_dmem_addr   (o_dmem_addr),
        .o_dmem_we     (o_dmem_we),
        .o_dmem_wdata  (o_dmem_wdata),
        .i_dmem_rdata  (i_dmem_rdata),
        .o_wb_pc       (o_wb_pc),
        .o_wb_insn     (o_wb_insn),
        .o_wb_stall    (o_wb_stall),
        .o_wb_rf_we    (o_wb_rf_we),
        .o_wb_rf_wsel  (o_wb_rf_wsel),
        .o_wb_rf_wdata (o_wb_rf_wdata),
        .o_wb_nzp_we   (o_wb_nzp_we),
        .o_wb_nzp      (o_wb_nzp)
    );

    initial begin
        gwe = 1'b0;
        forever #2 gwe = ~gwe;  // 4 ns period
    end

    // both memories, driven 1 ns after each rising edge
    initial begin
        word_t slot;
        i_insn       = nop_insn;
        i_dmem_rdata = '0;
        forever begin
            @(posedge gwe);
            #1;
            slot = o_pc - `LC4_RESET_PC;
            i_insn = (slot < 16'd64) ? imem[slot[5:0]] : nop_insn;  // past the program is nops
            i_dmem_rdata = dmem[o_dmem_addr];
            if (o_dmem_we) begin
                dmem[o_dmem_addr] = o_dmem_wdata;
                stores.push_back({o_dmem_addr, o_dmem_wdata});
            end
        end
    end

    // byte-swapped address, so every address bit shows up
    function automatic word_t fill_value(input word_t addr);
        return {addr[7:0], addr[15:8]} ^ 16'hc35a;
    endfunction

    function automatic nzp_t nzp_of(input word_t v);
        if (v[15]) begin
            return 3'b100;
        end
        return (v == '0) ? 3'b010 : 3'b001;
    endfunction

    // small assembler
    function automatic word_t add_reg(input reg_sel_t rd, input reg_sel_t rs, input reg_sel_t rt);
        return {`LC4_OP_ARITH, rd, rs, 3'b000, rt};
    endfunction

    function automatic word_t add_imm(input reg_sel_t rd, input reg_sel_t rs, input logic [4:0] imm);
        return {`LC4_OP_ARITH, rd, rs, 1'b1, imm};
    endfunction

    function automatic word_t and_reg(input reg_sel_t rd, input reg_sel_t rs, input reg_sel_t rt);
        return {`LC4_OP_LOGIC, rd, rs, 3'b000, rt};
    endfunction

    function automatic word_t set_const(input reg_sel_t rd, input logic [8:0] imm);
        return {`LC4_OP_CONST, rd, imm};
    endfunction

    function automatic word_t ldr(input reg_sel_t rd, input reg_sel_t rs, input logic [5:0] off);
        return {`LC4_OP_LDR, rd, rs, off};
    endfunction

    function automatic word_t str(input reg_sel_t rt, input reg_sel_t rs, input logic [5:0] off);
        return {`LC4_OP_STR, rt, rs, off};
    endfunction

    function automatic word_t branch(input nzp_t mask, input logic [8:0] imm);
        return {`LC4_OP_BR, mask, imm};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sel(input string name, input reg_sel_t got, input reg_sel_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_nzp(input string name, input nzp_t got, input nzp_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_stall(input string name, input stall_t got, input stall_t exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic bit trace_length(input int n);
        if (trace.size() != n) begin
            $display("wrong number of retired entries at t=%0t, %0d instead of %0d",
                     $time, trace.size(), n);
            errors++;
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic retired_at(input int idx, input word_t pc, input stall_t stall);
        word_t slot;
        slot = pc - `LC4_RESET_PC;
        check_word($sformatf("o_wb_pc[%0d]", idx), trace[idx].pc, pc);
        check_stall($sformatf("o_wb_stall[%0d]", idx), trace[idx].stall, stall);
        if (stall == `LC4_STALL_NONE) begin
            // a real entry carries the program word fetched at its pc
            check_word($sformatf("o_wb_insn[%0d]", idx), trace[idx].insn, imem[slot[5:0]]);
        end
    endtask

    task automatic wrote_reg(input int idx, input reg_sel_t sel, input word_t data);
        check_flag($sformatf("o_wb_rf_we[%0d]", idx), trace[idx].rf_we, 1'b1);
        check_sel($sformatf("o_wb_rf_wsel[%0d]", idx), trace[idx].sel, sel);
        check_word($sformatf("o_wb_rf_wdata[%0d]", idx), trace[idx].data, data);
        check_flag($sformatf("o_wb_nzp_we[%0d]", idx), trace[idx].nzp_we, 1'b1);
        check_nzp($sformatf("o_wb_nzp[%0d]", idx), trace[idx].nzp, nzp_of(data));  // sign of result
    endtask

    task automatic no_writes(input int idx);
        check_flag($sformatf("o_wb_rf_we[%0d]", idx), trace[idx].rf_we, 1'b0);
        check_flag($sformatf("o_wb_nzp_we[%0d]", idx), trace[idx].nzp_we, 1'b0);
    endtask

    task automatic clear_memories;
        int a;
        for (a = 0; a < 64; a++) begin
            imem[a[5:0]] = nop_insn;
        end
        for (a = 0; a < 65536; a++) begin
            dmem[a[15:0]] = fill_value(a[15:0]);
        end
        stores.delete();
    endtask

    // leaves reset high after 10 edges
    task automatic pulse_reset;
        @(posedge gwe);
        #1;
        i_rst = 1'b1;
        repeat (10) @(posedge gwe);
    endtask

    // release reset, collect entries until last_pc retires
    task automatic run_program(input word_t last_pc);
        int     cycles;
        logic   done;
        entry_t e;
        trace.delete();
        done   = 1'b0;
        cycles = 0;
        @(posedge gwe);
        #1;
        i_rst = 1'b0;
        while (!done && cycles < 200) begin
            @(negedge gwe);  // outputs settled mid cycle
            if (trace.size() > 0 || o_wb_stall != `LC4_STALL_BUBBLE) begin
                e.pc     = o_wb_pc;
                e.insn   = o_wb_insn;
                e.stall  = o_wb_stall;
                e.rf_we  = o_wb_rf_we;
                e.sel    = o_wb_rf_wsel;
                e.data   = o_wb_rf_wdata;
                e.nzp_we = o_wb_nzp_we;
                e.nzp    = o_wb_nzp;
                trace.push_back(e);
            end
            done = (o_wb_stall == `LC4_STALL_NONE) && (o_wb_pc == last_pc);
            cycles++;
        end
        if (!done) begin
            $display("timeout at t=%0t, pc %h never reached writeback", $time, last_pc);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start);
        if (errors == start) begin
            $display("%s: pass", name);
            passed++;
        end else begin
            $display("%s: %0d errors", name, errors - start);
            failed++;
        end
    endtask

    task automatic reset_state;
        int start;
        start = errors;
        clear_memories();
        pulse_reset();
        @(negedge gwe);
        check_word("o_pc", o_pc, `LC4_RESET_PC);
        check_stall("o_wb_stall", o_wb_stall, `LC4_STALL_BUBBLE);
        check_flag("o_wb_rf_we", o_wb_rf_we, 1'b0);
        check_flag("o_wb_nzp_we", o_wb_nzp_we, 1'b0);
        check_flag("o_dmem_we", o_dmem_we, 1'b0);
        finish_test("reset", start);
    endtask

    // each instruction reads the one before it, so MX and WX are both hit
    task automatic alu_chain;
        int         start;
        int         k;
        logic [8:0] c9;
        logic [4:0] i5;
        word_t      r1;
        word_t      r2;
        word_t      r3;
        word_t      r4;
        start = errors;
        c9 = 9'($urandom_range(0, 511));
        i5 = 5'($urandom_range(0, 31));
        r1 = {{7{c9[8]}}, c9};
        r2 = r1 + r1;
        r3 = r2 + {{11{i5[4]}}, i5};
        r4 = r3 & r2;
        clear_memories();
        imem[0] = set_const(3'd1, c9);
        imem[1] = add_reg(3'd2, 3'd1, 3'd1);
        imem[2] = add_imm(3'd3, 3'd2, i5);
        imem[3] = and_reg(3'd4, 3'd3, 3'd2);
        pulse_reset();
        run_program(16'h8203);
        if (trace_length(4)) begin
            for (k = 0; k < 4; k++) begin
                retired_at(k, 16'h8200 + 16'(k), `LC4_STALL_NONE);
            end
            wrote_reg(0, 3'd1, r1);
            wrote_reg(1, 3'd2, r2);
            wrote_reg(2, 3'd3, r3);
            wrote_reg(3, 3'd4, r4);
        end
        finish_test("alu chain", start);
    endtask

    task automatic store_load;
        int start;
        start = errors;
        clear_memories();
        imem[0] = set_const(3'd1, 9'h1f9);  // -7
        imem[1] = set_const(3'd2, 9'h040);
        imem[2] = str(3'd1, 3'd2, 6'd3);
        imem[3] = ldr(3'd3, 3'd2, 6'd3);
        pulse_reset();
        run_program(16'h8203);
        if (stores.size() != 1) begin
            $display("expected one data memory write, saw %0d", stores.size());
            errors++;
        end else begin
            check_word("o_dmem_addr", stores[0].addr, 16'h0043);
            check_word("o_dmem_wdata", stores[0].data, 16'hfff9);
        end
        if (trace_length(4)) begin
            retired_at(2, 16'h8202, `LC4_STALL_NONE);
            no_writes(2);
            retired_at(3, 16'h8203, `LC4_STALL_NONE);
            wrote_reg(3, 3'd3, 16'hfff9);
        end
        finish_test("store then load", start);
    endtask

    task automatic load_use;
        int    start;
        word_t loaded;
        start  = errors;
        loaded = fill_value(16'h002e);
        clear_memories();
        imem[0] = set_const(3'd2, 9'h030);
        imem[1] = ldr(3'd1, 3'd2, 6'h3e);    // offset -2
        imem[2] = add_reg(3'd3, 3'd1, 3'd2);
        pulse_reset();
        run_program(16'h8202);
        if (trace_length(4)) begin
            retired_at(1, 16'h8201, `LC4_STALL_NONE);
            wrote_reg(1, 3'd1, loaded);
            retired_at(2, 16'h8202, `LC4_STALL_LOAD);  // the one inserted bubble
            no_writes(2);
            retired_at(3, 16'h8202, `LC4_STALL_NONE);
            wrote_reg(3, 3'd3, loaded + 16'h0030);
        end
        finish_test("load use", start);
    endtask

    task automatic branches;
        int start;
        start = errors;
        clear_memories();
        imem[0] = set_const(3'd1, 9'd0);
        imem[1] = branch(3'b010, 9'd3);      // BRz to 8205, taken
        imem[2] = set_const(3'd2, 9'd1);     // flushed
        imem[3] = set_const(3'd3, 9'd2);     // flushed
        imem[4] = set_const(3'd4, 9'd3);     // skipped
        imem[5] = set_const(3'd5, 9'd5);
        imem[6] = branch(3'b100, 9'd2);      // BRn, falls through
        imem[7] = add_imm(3'd6, 3'd5, 5'd1);
        pulse_reset();
        run_program(16'h8207);
        if (trace_length(7)) begin
            wrote_reg(0, 3'd1, 16'h0000);
            retired_at(1, 16'h8201, `LC4_STALL_NONE);
            no_writes(1);
            retired_at(2, 16'h8202, `LC4_STALL_BUBBLE);
            no_writes(2);
            retired_at(3, 16'h8203, `LC4_STALL_BUBBLE);
            no_writes(3);
            retired_at(4, 16'h8205, `LC4_STALL_NONE);
            wrote_reg(4, 3'd5, 16'h0005);
            retired_at(5, 16'h8206, `LC4_STALL_NONE);
            no_writes(5);
            retired_at(6, 16'h8207, `LC4_STALL_NONE);
            wrote_reg(6, 3'd6, 16'h0006);
        end
        finish_test("branches", start);
    endtask

    initial begin
        void'($urandom(83665));
        i_rst  = 1'b1;
        errors = 0;
        passed = 0;
        failed = 0;
        reset_state();
        alu_chain();
        store_load();
        load_use();
        branches();
        $display("tests passed %0d, failed %0d", passed, failed);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+src
src/lc4_pkg.sv
src/lc4_stage_if.sv
src/lc4_fetch.sv
src/lc4_decode.sv
src/lc4_regfile.sv
src/lc4_execute.sv
src/lc4_mem_writeback.sv
src/lc4_core.sv
tests/lc4_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the LC4 pipeline testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --timescale 1ns/100ps --top-module lc4_tb -f all.f -o lc4_sim \
    && ./obj_dir/lc4_sim | tee /dev/stderr | grep -qF "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
